//--- project.f
logic/engine_pkg.sv
logic/burst_deser.sv
logic/weight_store.sv
logic/line_sequencer.sv
logic/cmac_array.sv
logic/channel_reduce.sv
logic/writeback.sv
logic/conv_engine.sv
tb/clock_gen.sv
tb/tb_conv_engine.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  - logic/engine_pkg.sv
  - logic/burst_deser.sv
  - logic/weight_store.sv
  - logic/line_sequencer.sv
  - logic/cmac_array.sv
  - logic/channel_reduce.sv
  - logic/writeback.sv
  - logic/conv_engine.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/tb_conv_engine.sv

//--- tb/tb_conv_engine.sv
`timescale 1ns/1ns

module tb_conv_engine import engine_pkg::*; ();

	logic    clk;
	logic    rst;
	logic    i_start;
	job_t    i_job;
	word_t   i_word;
	logic    i_word_valid;
	result_t o_result;
	logic    o_result_valid;
	logic    o_busy;
	logic    o_done;

	int      seed = 32'h6499_5fe0;
	int      cycle = 0;       // Rising edges since time zero
	int      last_cycle = 0;  // Cycle in which the latest word was driven
	result_t res_q [$];       // Results seen on the output
	logic    done_q [$];      // o_done beside each result
	int      stamp_q [$];     // Cycle of each result

	clock_gen clock_gen_inst (.o_clk(clk), .o_rst(rst));

	conv_engine conv_engine_inst (
		.clk, .rst, .i_start, .i_job, .i_word, .i_word_valid,
		.o_result, .o_result_valid, .o_busy, .o_done
	);

	always @(posedge clk) cycle++;

	// Falling edge sees the outputs settled
	always @(negedge clk) begin
		if (o_result_valid) begin
			res_q.push_back(o_result);
			done_q.push_back(o_done);
			stamp_q.push_back(cycle);
		end
	end

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic check_result(input string name, input result_t got, input result_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("CHECK FAILED %s got addr %h value %h expected addr %h value %h",
				name, got.addr, got.value, exp.addr, exp.value));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_stop($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (o_busy) begin
			if (waited > 100) fail_stop("Timed out waiting for o_busy to fall");
			next_cycle();
			waited++;
		end
	endtask

	// Fill 0 is random, 1 is all ones, 2 mixes the extreme codes
	function automatic word_t pick_word(input int fill, input int idx);
		case (fill)
			0:       return word_t'($random(seed));
			1:       return word_t'(1);
			default: return (idx % 3 == 1) ? word_t'(16'h7fff) : word_t'(16'h8000);
		endcase
	endfunction

	// Wrapped sum over taps and lanes of data times weight
	function automatic word_t model_point(input job_t jb, input burst_t wts [MAX_KERNEL],
			input burst_t dat [$], input int p);
		int acc;
		acc = 0;
		for (int t = 0; t < jb.kernel; t++) begin
			for (int l = 0; l < BURST_LEN; l++) begin
				acc += int'(dat[p * jb.kernel + t][l]) * int'(wts[t][l]);
			end
		end
		return word_t'(acc);  // Low 16 bits only
	endfunction

	task automatic send_word(input word_t w, input int gap_max);
		int gap;
		gap = (gap_max > 0) ? int'($unsigned($random(seed)) % (gap_max + 1)) : 0;
		i_word       = w;
		i_word_valid = 1'b1;
		last_cycle   = cycle;
		next_cycle();
		i_word_valid = 1'b0;
		i_start      = 1'b0;  // A start raised beside this word lasts one cycle too
		repeat (gap) next_cycle();
	endtask

	task automatic run_job(input job_t jb, input int fill, input int gap_max,
			input bit poke_start, input bit check_timing);
		burst_t  wts [MAX_KERNEL];
		burst_t  dat [$];
		burst_t  b;
		result_t exp;
		int      waited;
		for (int t = 0; t < jb.kernel; t++) begin
			for (int l = 0; l < BURST_LEN; l++) wts[t][l] = pick_word(fill, l);
		end
		for (int k = 0; k < jb.o_side * jb.kernel; k++) begin
			for (int l = 0; l < BURST_LEN; l++) b[l] = pick_word(fill, l + k);
			dat.push_back(b);
		end
		wait_idle();
		res_q.delete();
		done_q.delete();
		stamp_q.delete();
		i_job   = jb;
		i_start = 1'b1;
		next_cycle();
		i_start = 1'b0;
		check_flag("o_busy", o_busy, 1'b1);  // High the cycle after start
		for (int t = 0; t < jb.kernel; t++) begin
			for (int l = 0; l < BURST_LEN; l++) send_word(wts[t][l], gap_max);
		end
		for (int k = 0; k < jb.o_side * jb.kernel; k++) begin
			for (int l = 0; l < BURST_LEN; l++) begin
				if (poke_start && k == 1 && l == 0) begin
					check_flag("o_busy", o_busy, 1'b1);
					i_job   = '{kernel: tap_t'(1), o_side: count_t'(1), result_base: '1};
					i_start = 1'b1;  // Must be ignored mid job
				end
				send_word(dat[k][l], gap_max);
			end
		end
		// Results come in point order with addresses counting up from the base
		for (int p = 0; p < jb.o_side; p++) begin
			waited = 0;
			while (res_q.size() <= p) begin
				if (waited > 100) fail_stop("Timed out waiting for a result");
				next_cycle();
				waited++;
			end
			exp.addr  = jb.result_base + addr_t'(p);
			exp.value = model_point(jb, wts, dat, p);
			check_result("o_result", res_q[p], exp);
			check_flag("o_done", done_q[p], p == int'(jb.o_side) - 1);
			if (check_timing) begin
				check_flag("o_result_valid 7 cycles after last word",
					stamp_q[p] == last_cycle + 7, 1'b1);
			end
		end
		wait_idle();
		check_flag("result count", res_q.size() == int'(jb.o_side), 1'b1);
	endtask

	task automatic test_reset_state();
		check_flag("o_busy", o_busy, 1'b0);
		check_flag("o_done", o_done, 1'b0);
		check_flag("o_result_valid", o_result_valid, 1'b0);
	endtask

	task automatic test_single_point();
		run_job('{kernel: tap_t'(1), o_side: count_t'(1), result_base: addr_t'('h100)},
			1, 0, 1'b0, 1'b1);  // Sixteen lanes of ones give 16
	endtask

	task automatic test_gapped_random();
		run_job('{kernel: tap_t'(3), o_side: count_t'(5), result_base: addr_t'('h2000)},
			0, 3, 1'b0, 1'b0);
	endtask

	task automatic test_back_to_back();
		run_job('{kernel: tap_t'(MAX_KERNEL), o_side: count_t'(3), result_base: addr_t'('h3000)},
			0, 0, 1'b0, 1'b0);
		run_job('{kernel: tap_t'(2), o_side: count_t'(4), result_base: addr_t'('h3_0000)},
			0, 0, 1'b0, 1'b0);
	endtask

	task automatic test_busy_start();
		run_job('{kernel: tap_t'(2), o_side: count_t'(3), result_base: addr_t'('h4000)},
			0, 1, 1'b1, 1'b0);
	endtask

	task automatic test_wrap();
		run_job('{kernel: tap_t'(2), o_side: count_t'(2), result_base: addr_t'('h5000)},
			2, 0, 1'b0, 1'b0);
	endtask

	initial begin
		int waited;
		i_start      = 1'b0;
		i_job        = '0;
		i_word       = '0;
		i_word_valid = 1'b0;
		waited       = 0;
		next_cycle();
		while (rst) begin
			if (waited > 50) fail_stop("Timed out waiting for reset to be released");
			next_cycle();
			waited++;
		end
		test_reset_state();
		test_single_point();
		test_gapped_random();
		test_back_to_back();
		test_busy_start();
		test_wrap();
		$display("sim passed");
		$finish;
	end

endmodule

//--- tb/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
	output logic o_clk,
	output logic o_rst
);

	// 10 ns period, first rising edge at 5 ns
	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	initial begin
		o_rst = 1'b1;
		repeat (10) @(posedge o_clk);  // Reset held for 10 cycles
		o_rst <= 1'b0;                  // Released on an edge, after the flops have sampled
	end

endmodule

//--- logic/conv_engine.sv
`timescale 1ns/1ns

module conv_engine import engine_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_start,
	input  job_t    i_job,
	input  word_t   i_word,
	input  logic    i_word_valid,
	output result_t o_result,
	output logic    o_result_valid,
	output logic    o_busy,
	output logic    o_done
);

	burst_t burst;           // Deserializer to sequencer
	logic   burst_valid;
	logic   wr_en;           // Sequencer to weight store
	tap_t   wr_tap;
	tap_t   rd_tap;
	burst_t rd_burst;
	atom_t  atom;            // Sequencer to MAC lanes
	logic   atom_valid;
	job_t   job;             // Latched job for writeback
	burst_t lane_sum;
	logic   lane_sum_valid;
	word_t  sum;
	logic   sum_valid;
	logic   job_done;

	burst_deser burst_deser_inst (
		.clk, .rst, .i_word, .i_word_valid,
		.o_burst(burst), .o_burst_valid(burst_valid)
	);

	weight_store weight_store_inst (
		.clk, .i_wr_en(wr_en), .i_wr_tap(wr_tap), .i_wr_burst(burst),
		.i_rd_tap(rd_tap), .o_rd_burst(rd_burst)
	);

	line_sequencer line_sequencer_inst (
		.clk, .rst, .i_start, .i_job,
		.i_burst(burst), .i_burst_valid(burst_valid), .i_rd_burst(rd_burst),
		.i_job_done(job_done), .o_wr_en(wr_en), .o_wr_tap(wr_tap), .o_rd_tap(rd_tap),
		.o_atom(atom), .o_atom_valid(atom_valid), .o_job(job), .o_busy, .o_done
	);

	cmac_array cmac_array_inst (
		.clk, .rst, .i_atom(atom), .i_atom_valid(atom_valid),
		.o_lane_sum(lane_sum), .o_lane_sum_valid(lane_sum_valid)
	);

	channel_reduce channel_reduce_inst (
		.clk, .rst, .i_lane_sum(lane_sum), .i_lane_sum_valid(lane_sum_valid),
		.o_sum(sum), .o_sum_valid(sum_valid)
	);

	writeback writeback_inst (
		.clk, .rst, .i_sum(sum), .i_sum_valid(sum_valid), .i_job(job),
		.o_result, .o_result_valid, .o_job_done(job_done)
	);

endmodule

//--- logic/writeback.sv
`timescale 1ns/1ns

module writeback import engine_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  word_t   i_sum,
	input  logic    i_sum_valid,
	input  job_t    i_job,
	output result_t o_result,
	output logic    o_result_valid,
	output logic    o_job_done
);

	count_t count_q;     // Points already written this job
	logic   last_point;

	assign last_point = (count_q == count_t'(i_job.o_side - 1'b1));

	// Result payload
	always_ff @(posedge clk) begin
		if (i_sum_valid) begin
			o_result.addr  <= i_job.result_base + addr_t'(count_q);
			o_result.value <= i_sum;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count_q        <= '0;
			o_result_valid <= 1'b0;
			o_job_done     <= 1'b0;
		end else begin
			o_result_valid <= i_sum_valid;
			o_job_done     <= i_sum_valid && last_point;  // Rides with the final result
			if (i_sum_valid) begin
				count_q <= last_point ? '0 : count_q + 1'b1;  // Ready for the next job
			end
		end
	end

endmodule

//--- logic/channel_reduce.sv
`timescale 1ns/1ns

module channel_reduce import engine_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  burst_t i_lane_sum,
	input  logic   i_lane_sum_valid,
	output word_t  o_sum,
	output logic   o_sum_valid
);

	// Heap layout, node n sums children 2n and 2n+1
	// Nodes BURST_LEN/2 and up take their operands straight from the input lanes
	word_t node_q [1:BURST_LEN-1];

	logic [REDUCE_STAGES-1:0] vld_q;  // One bit per tree level

	for (genvar n = 1; n < BURST_LEN; n++) begin : g_node
		if (n >= BURST_LEN / 2) begin : g_leaf
			always_ff @(posedge clk) begin
				node_q[n] <= i_lane_sum[2*n-BURST_LEN] + i_lane_sum[2*n-BURST_LEN+1];
			end
		end else begin : g_inner
			always_ff @(posedge clk) begin
				node_q[n] <= node_q[2*n] + node_q[2*n+1];  // Free running, new burst each cycle
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[REDUCE_STAGES-2:0], i_lane_sum_valid};
		end
	end

	assign o_sum       = node_q[1];  // Root
	assign o_sum_valid = vld_q[REDUCE_STAGES-1];

endmodule

//--- logic/cmac_array.sv
`timescale 1ns/1ns

module cmac_array import engine_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  atom_t  i_atom,
	input  logic   i_atom_valid,
	output burst_t o_lane_sum,
	output logic   o_lane_sum_valid
);

	burst_t acc_q;     // Per lane running sum over taps
	burst_t acc_next;

	// Products and sums wrap at 16 bits
	always_comb begin
		for (int l = 0; l < BURST_LEN; l++) begin
			acc_next[l] = i_atom.data[l] * i_atom.weight[l]
				+ (i_atom.first ? word_t'(0) : acc_q[l]);  // First tap restarts from zero
		end
	end

	always_ff @(posedge clk) begin
		if (i_atom_valid) begin
			acc_q <= acc_next;
		end
		if (i_atom_valid && i_atom.last) begin
			o_lane_sum <= acc_next;  // Point finished, hand lanes to the tree
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_lane_sum_valid <= 1'b0;
		end else begin
			o_lane_sum_valid <= i_atom_valid && i_atom.last;
		end
	end

endmodule

//--- logic/line_sequencer.sv
`timescale 1ns/1ns

module line_sequencer import engine_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   i_start,
	input  job_t   i_job,
	input  burst_t i_burst,
	input  logic   i_burst_valid,
	input  burst_t i_rd_burst,
	input  logic   i_job_done,
	output logic   o_wr_en,
	output tap_t   o_wr_tap,
	output tap_t   o_rd_tap,
	output atom_t  o_atom,
	output logic   o_atom_valid,
	output job_t   o_job,
	output logic   o_busy,
	output logic   o_done
);

	typedef enum logic [1:0] {
		ST_IDLE,  // Waiting for a job
		ST_LOAD,  // Weight bursts arriving
		ST_RUN    // Data bursts arriving
	} state_t;

	state_t state_q;
	job_t   job_q;     // Held for the whole job, writeback reads it too
	tap_t   tap_q;     // Current tap in both phases
	logic   last_tap;

	assign last_tap = (tap_q == tap_t'(job_q.kernel - 1'b1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= ST_IDLE;
			job_q   <= '0;
			tap_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_start) begin  // Start only seen while idle
						job_q   <= i_job;
						tap_q   <= '0;
						state_q <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					if (i_burst_valid && last_tap) state_q <= ST_RUN;  // All weights stored
				end
				ST_RUN: begin
					if (i_job_done) state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
			// Tap walks 0..kernel-1 and wraps, in load and in run alike
			if (state_q != ST_IDLE && i_burst_valid) begin
				tap_q <= last_tap ? '0 : tap_q + 1'b1;
			end
		end
	end

	// Weight phase writes
	assign o_wr_en  = (state_q == ST_LOAD) && i_burst_valid;
	assign o_wr_tap = tap_q;

	// Run phase pairs each data burst with its tap weight
	assign o_rd_tap     = tap_q;
	assign o_atom_valid = (state_q == ST_RUN) && i_burst_valid;
	assign o_atom       = '{data: i_burst, weight: i_rd_burst, first: (tap_q == '0), last: last_tap};

	assign o_job  = job_q;
	assign o_busy = (state_q != ST_IDLE);
	assign o_done = i_job_done && (state_q == ST_RUN);  // Same cycle as the last result

endmodule

//--- logic/weight_store.sv
`timescale 1ns/1ns

module weight_store import engine_pkg::*; (
	input  logic   clk,
	input  logic   i_wr_en,
	input  tap_t   i_wr_tap,
	input  burst_t i_wr_burst,
	input  tap_t   i_rd_tap,
	output burst_t o_rd_burst
);

	// One weight burst per kernel tap
	burst_t mem_q [MAX_KERNEL];

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem_q[i_wr_tap] <= i_wr_burst;  // Visible after this edge
		end
	end

	// Combinational read so the weight joins the data burst in the same cycle
	assign o_rd_burst = mem_q[i_rd_tap];

endmodule

//--- logic/burst_deser.sv
`timescale 1ns/1ns

module burst_deser import engine_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  word_t  i_word,
	input  logic   i_word_valid,
	output burst_t o_burst,
	output logic   o_burst_valid
);

	logic [LANE_W-1:0] word_cnt_q;  // Words already in the current burst
	burst_t            shift_q;

	// Newest word enters at the top lane, so the first word ends in lane 0
	always_ff @(posedge clk) begin
		if (i_word_valid) begin
			shift_q <= {i_word, shift_q[BURST_LEN-1:1]};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt_q    <= '0;
			o_burst_valid <= 1'b0;
		end else begin
			o_burst_valid <= 1'b0;
			if (i_word_valid) begin
				word_cnt_q <= word_cnt_q + 1'b1;  // Wraps after BURST_LEN words
				if (word_cnt_q == LANE_W'(BURST_LEN - 1)) begin
					o_burst_valid <= 1'b1;  // Burst complete next cycle
				end
			end
		end
	end

	assign o_burst = shift_q;  // Stable until the next word arrives

endmodule

//--- logic/engine_pkg.sv
package engine_pkg;

	// Core geometry
	localparam int BURST_LEN     = 16;                 // Channel lanes per burst, power of two
	localparam int MAX_KERNEL    = 9;                  // Largest kernel length in taps
	localparam int REDUCE_STAGES = $clog2(BURST_LEN);  // Adder tree depth
	localparam int LANE_W        = $clog2(BURST_LEN);  // Word index within a burst

	// Field widths
	localparam int WORD_W  = 16;
	localparam int ADDR_W  = 30;
	localparam int TAP_W   = 4;
	localparam int COUNT_W = 8;

	typedef logic signed [WORD_W-1:0] word_t;   // Data, weight or result word
	typedef word_t [BURST_LEN-1:0] burst_t;     // Lane 0 is the first word received
	typedef logic [ADDR_W-1:0] addr_t;          // Word address
	typedef logic [TAP_W-1:0] tap_t;            // Kernel tap index
	typedef logic [COUNT_W-1:0] count_t;        // Output point counter

	typedef struct packed {
		tap_t   kernel;       // 1 to MAX_KERNEL
		count_t o_side;       // Output points, at least 1
		addr_t  result_base;  // Address of the first result
	} job_t;

	typedef struct packed {
		burst_t data;
		burst_t weight;
		logic   first;  // Tap 0 of a point
		logic   last;   // Final tap of a point
	} atom_t;

	typedef struct packed {
		addr_t addr;
		word_t value;
	} result_t;

endpackage
